/* include/soc_defs.svh */
// ----------------------------------------------------------
// SoC bus constants
// region numbers, misc register map, widths and the
// fixed words returned by the system bus
// ----------------------------------------------------------
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W        32
`define SOC_DATA_W        32
`define SOC_STRB_W        4

// address regions, taken from the top nibble
`define SOC_REGION_MSB    31
`define SOC_REGION_MISC   4'h2
`define SOC_REGION_RAM    4'h4

// misc register word indices, from address bits 6..2
`define SOC_REG_LED        5'd0
`define SOC_REG_BTN        5'd1
`define SOC_REG_SOC_VER    5'd2
`define SOC_REG_FLASH_SEL  5'd13
`define SOC_REG_GENIO_IN   5'd17
`define SOC_REG_GENIO_OUT  5'd18
`define SOC_REG_GENIO_OE   5'd19
`define SOC_REG_GENIO_W2S  5'd20
`define SOC_REG_GENIO_W2C  5'd21

// peripheral widths
`define SOC_GENIO_W       30
`define SOC_LED_W         9
`define SOC_BTN_W         8

// fixed values
`define SOC_RELOAD_MAGIC  24'hD0F1A5
`define SOC_VERSION       32'h0000_0000
`define SOC_BUS_ERR_DATA  32'hDEAD_BEEF
`define SOC_RAM_WORDS     256

`endif

/* verilog/soc_pkg.sv */
// ----------------------------------------------------------
// SoC bus types
// bus words, register index, general I/O vector and the
// flash-select sequencer states
// ----------------------------------------------------------
`default_nettype none

`include "soc_defs.svh"

package soc_pkg;

	typedef logic [`SOC_ADDR_W-1:0] addr_t;
	typedef logic [`SOC_DATA_W-1:0] data_t;
	typedef logic [`SOC_STRB_W-1:0] strb_t;

	// misc register word index
	typedef logic [4:0] reg_idx_t;

	typedef logic [`SOC_GENIO_W-1:0] genio_t;

	typedef enum logic [2:0] {
		fsel_idle,
		fsel_settle,
		fsel_pulse,
		fsel_hold,
		fsel_reload
	} fsel_state_t;

endpackage

`default_nettype wire

/* verilog/soc_bus_if.sv */
// ----------------------------------------------------------
// Decoded bus target link
// valid/ready access from the decoder to one target
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface soc_bus_if
	import soc_pkg::*;
	();

	logic  valid;
	addr_t addr;
	data_t wdata;
	strb_t wstrb;
	data_t rdata;
	logic  ready;

	// decoder side
	modport host (
		output valid, addr, wdata, wstrb,
		input  rdata, ready
	);

	// peripheral side
	modport target (
		input  valid, addr, wdata, wstrb,
		output rdata, ready
	);

endinterface

`default_nettype wire

/* verilog/bus_decoder.sv */
// ----------------------------------------------------------
// System bus address decoder
// routes the host access by region, muxes read data and
// ready, and answers unmapped regions with a bus error
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module bus_decoder
	import soc_pkg::*;
	(
	input  wire        valid_i,
	input  wire addr_t addr_i,
	input  wire data_t wdata_i,
	input  wire strb_t wstrb_i,
	output data_t      rdata_o,
	output logic       ready_o,
	output logic       bus_error_irq_o,
	soc_bus_if.host    misc_bus,
	soc_bus_if.host    ram_bus
);

	logic [3:0] region;
	logic       hit_misc;
	logic       hit_ram;

	assign region   = addr_i[`SOC_REGION_MSB -: 4];
	assign hit_misc = (region == `SOC_REGION_MISC);
	assign hit_ram  = (region == `SOC_REGION_RAM);

	// request fan-out, only the addressed target sees valid
	assign misc_bus.valid = valid_i && hit_misc;
	assign misc_bus.addr  = addr_i;
	assign misc_bus.wdata = wdata_i;
	assign misc_bus.wstrb = wstrb_i;

	assign ram_bus.valid = valid_i && hit_ram;
	assign ram_bus.addr  = addr_i;
	assign ram_bus.wdata = wdata_i;
	assign ram_bus.wstrb = wstrb_i;

	// unmapped access answers at once and flags the CPU
	assign bus_error_irq_o = valid_i && !hit_misc && !hit_ram;

	always_comb begin
		if (hit_misc) begin
			rdata_o = misc_bus.rdata;
		end else if (hit_ram) begin
			rdata_o = ram_bus.rdata;
		end else begin
			rdata_o = `SOC_BUS_ERR_DATA;
		end
	end

	assign ready_o = misc_bus.ready || ram_bus.ready || bus_error_irq_o;

endmodule

`default_nettype wire

/* verilog/misc_regs.sv */
// ----------------------------------------------------------
// Misc register block
// LED, buttons, version/trace, general I/O and the
// flash-select write capture; zero wait state access
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module misc_regs
	import soc_pkg::*;
	(
	input  wire                  clk48m_i,
	input  wire                  rst_i,
	soc_bus_if.target            bus,
	input  wire [`SOC_BTN_W-1:0] btn_i,
	input  wire genio_t          genio_in_i,
	output logic [`SOC_LED_W-1:0] led_o,
	output genio_t               genio_out_o,
	output genio_t               genio_oe_o,
	output logic                 trace_en_o,
	input  wire                  fsel_d_i,
	output logic                 sel_wr_o,
	output data_t                sel_wdata_o
);

	reg_idx_t              reg_idx;
	logic                  wr_en;
	genio_t                wr_genio;
	logic [`SOC_BTN_W-1:0] btn_n;

	assign reg_idx  = bus.addr[6:2];
	assign wr_genio = bus.wdata[`SOC_GENIO_W-1:0];
	// buttons are active low on the board
	assign btn_n    = ~btn_i;

	// every access completes in the cycle it is presented
	assign bus.ready = bus.valid;
	assign wr_en     = bus.valid && (bus.wstrb != '0);

	// ------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------
	always_ff @(posedge clk48m_i) begin
		if (rst_i) begin
			led_o       <= '0;
			trace_en_o  <= 1'b0;
			genio_out_o <= '0;
			genio_oe_o  <= '0;
		end else if (wr_en) begin
			case (reg_idx)
				`SOC_REG_LED: begin
					led_o <= bus.wdata[`SOC_LED_W-1:0];
				end
				`SOC_REG_SOC_VER: begin
					trace_en_o <= bus.wdata[0];
				end
				`SOC_REG_GENIO_OUT: begin
					genio_out_o <= wr_genio;
				end
				`SOC_REG_GENIO_OE: begin
					genio_oe_o <= wr_genio;
				end
				// set and clear aliases only touch the ones written
				`SOC_REG_GENIO_W2S: begin
					genio_out_o <= genio_out_o | wr_genio;
				end
				`SOC_REG_GENIO_W2C: begin
					genio_out_o <= genio_out_o & ~wr_genio;
				end
				default: begin
					led_o <= led_o;
				end
			endcase
		end
	end

	// flash select is sequenced elsewhere, hand over the raw write
	assign sel_wr_o    = wr_en && (reg_idx == `SOC_REG_FLASH_SEL);
	assign sel_wdata_o = bus.wdata;

	// ------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------
	always_comb begin
		case (reg_idx)
			`SOC_REG_LED:       bus.rdata = data_t'(led_o);
			`SOC_REG_BTN:       bus.rdata = data_t'(btn_n);
			`SOC_REG_SOC_VER:   bus.rdata = `SOC_VERSION;
			`SOC_REG_FLASH_SEL: bus.rdata = data_t'(fsel_d_i);
			`SOC_REG_GENIO_IN:  bus.rdata = data_t'(genio_in_i);
			`SOC_REG_GENIO_OUT: bus.rdata = data_t'(genio_out_o);
			`SOC_REG_GENIO_OE:  bus.rdata = data_t'(genio_oe_o);
			default:            bus.rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/fsel_sequencer.sv */
// ----------------------------------------------------------
// Flash select sequencer
// clocks the select flop a few cycles after the write and
// then pulls PROGRAMN low if a reload was requested
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module fsel_sequencer
	import soc_pkg::*;
	(
	input  wire        clk48m_i,
	input  wire        rst_i,
	input  wire        sel_wr_i,
	input  wire data_t sel_wdata_i,
	output logic       fsel_d_o,
	output logic       fsel_c_o,
	output logic       programn_o
);

	// count values at which the state is left
	localparam logic [2:0] cnt_start = 3'd7;
	localparam logic [2:0] cnt_pulse = 3'd6;
	localparam logic [2:0] cnt_hold  = 3'd3;
	localparam logic [2:0] cnt_last  = 3'd1;

	fsel_state_t state_q;
	logic [2:0]  cnt_q;
	logic        reload_pend_q;
	logic        reload_q;

	always_ff @(posedge clk48m_i) begin
		if (rst_i) begin
			state_q       <= fsel_idle;
			cnt_q         <= '0;
			fsel_d_o      <= 1'b0;
			reload_pend_q <= 1'b0;
			reload_q      <= 1'b0;
		end else if (sel_wr_i) begin
			// a new write restarts the sequence, a pending reload is kept
			fsel_d_o <= sel_wdata_i[0];
			state_q  <= fsel_settle;
			cnt_q    <= cnt_start;
			if (sel_wdata_i[`SOC_DATA_W-1:8] == `SOC_RELOAD_MAGIC) begin
				reload_pend_q <= 1'b1;
			end
		end else begin
			case (state_q)
				fsel_settle: begin
					cnt_q <= cnt_q - 3'd1;
					if (cnt_q == cnt_pulse) begin
						state_q <= fsel_pulse;
					end
				end
				fsel_pulse: begin
					cnt_q <= cnt_q - 3'd1;
					if (cnt_q == cnt_hold) begin
						state_q <= fsel_hold;
					end
				end
				fsel_hold: begin
					cnt_q <= cnt_q - 3'd1;
					if (cnt_q == cnt_last) begin
						state_q  <= reload_pend_q ? fsel_reload : fsel_idle;
						reload_q <= reload_pend_q;
					end
				end
				fsel_idle, fsel_reload: begin
					cnt_q <= '0;
				end
				default: begin
					state_q <= fsel_idle;
				end
			endcase
		end
	end

	// select flop clock, three cycles wide
	assign fsel_c_o   = (state_q == fsel_pulse);
	assign programn_o = ~reload_q;

endmodule

`default_nettype wire

/* verilog/scratch_ram.sv */
// ----------------------------------------------------------
// Scratch RAM
// byte writable word memory, one wait state per access
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module scratch_ram
	import soc_pkg::*;
	(
	input  wire       clk48m_i,
	input  wire       rst_i,
	soc_bus_if.target bus
);

	localparam int ram_aw = $clog2(`SOC_RAM_WORDS);

	data_t             mem [`SOC_RAM_WORDS];
	data_t             rdata_q;
	logic [ram_aw-1:0] word_idx;
	logic              ready_q;
	logic              start;

	assign word_idx = bus.addr[ram_aw+1:2];
	// no new access while the finished one is still on the bus
	assign start    = bus.valid && !ready_q;

	always_ff @(posedge clk48m_i) begin
		if (start) begin
			for (int b = 0; b < `SOC_STRB_W; b++) begin
				if (bus.wstrb[b]) begin
					mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
			rdata_q <= mem[word_idx];
		end
	end

	always_ff @(posedge clk48m_i) begin
		if (rst_i) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= start;
		end
	end

	assign bus.ready = ready_q && bus.valid;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

/* verilog/soc.sv */
// ----------------------------------------------------------
// SoC system bus top level
// host port, address decoder, misc registers, scratch RAM
// and the flash-select sequencer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module soc
	import soc_pkg::*;
	(
	input  wire                   clk48m_i,
	input  wire                   rst_i,
	input  wire                   bus_valid_i,
	input  wire addr_t            bus_addr_i,
	input  wire data_t            bus_wdata_i,
	input  wire strb_t            bus_wstrb_i,
	output data_t                 bus_rdata_o,
	output logic                  bus_ready_o,
	output logic                  bus_error_irq_o,
	input  wire [`SOC_BTN_W-1:0]  btn_i,
	output logic [`SOC_LED_W-1:0] led_o,
	input  wire genio_t           genio_in_i,
	output genio_t                genio_out_o,
	output genio_t                genio_oe_o,
	output logic                  trace_en_o,
	output logic                  fsel_d_o,
	output logic                  fsel_c_o,
	output logic                  programn_o
);

	logic  sel_wr;
	data_t sel_wdata;

	soc_bus_if misc_bus ();
	soc_bus_if ram_bus ();

	bus_decoder u_decoder (
		.valid_i         (bus_valid_i),
		.addr_i          (bus_addr_i),
		.wdata_i         (bus_wdata_i),
		.wstrb_i         (bus_wstrb_i),
		.rdata_o         (bus_rdata_o),
		.ready_o         (bus_ready_o),
		.bus_error_irq_o (bus_error_irq_o),
		.misc_bus        (misc_bus.host),
		.ram_bus         (ram_bus.host)
	);

	misc_regs u_misc (
		.clk48m_i    (clk48m_i),
		.rst_i       (rst_i),
		.bus         (misc_bus.target),
		.btn_i       (btn_i),
		.genio_in_i  (genio_in_i),
		.led_o       (led_o),
		.genio_out_o (genio_out_o),
		.genio_oe_o  (genio_oe_o),
		.trace_en_o  (trace_en_o),
		.fsel_d_i    (fsel_d_o),
		.sel_wr_o    (sel_wr),
		.sel_wdata_o (sel_wdata)
	);

	scratch_ram u_ram (
		.clk48m_i (clk48m_i),
		.rst_i    (rst_i),
		.bus      (ram_bus.target)
	);

	fsel_sequencer u_fsel (
		.clk48m_i    (clk48m_i),
		.rst_i       (rst_i),
		.sel_wr_i    (sel_wr),
		.sel_wdata_i (sel_wdata),
		.fsel_d_o    (fsel_d_o),
		.fsel_c_o    (fsel_c_o),
		.programn_o  (programn_o)
	);

endmodule

`default_nettype wire

/* bench/tb_soc.sv */
// ----------------------------------------------------------
// SoC system bus testbench
// random misc, RAM, bus error and flash-select accesses
// checked against a reference model of the register map
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module tb_soc
	import soc_pkg::*;
	();

	logic                  clk48m;
	logic                  rst;
	logic                  bus_valid;
	addr_t                 bus_addr;
	data_t                 bus_wdata;
	strb_t                 bus_wstrb;
	data_t                 bus_rdata;
	logic                  bus_ready;
	logic                  bus_error_irq;
	logic [`SOC_BTN_W-1:0] btn;
	logic [`SOC_LED_W-1:0] led;
	genio_t                genio_in;
	genio_t                genio_out;
	genio_t                genio_oe;
	logic                  trace_en;
	logic                  fsel_d;
	logic                  fsel_c;
	logic                  programn;

	// reference model state
	logic [`SOC_LED_W-1:0] led_m;
	logic                  trace_m;
	genio_t                genio_out_m;
	genio_t                genio_oe_m;
	logic                  fsel_d_m;
	logic                  reload_m;
	data_t                 ram_m [`SOC_RAM_WORDS];
	logic [15:0]           lfsr_q;

	reg_idx_t mapped_idx [9] = '{`SOC_REG_LED, `SOC_REG_BTN, `SOC_REG_SOC_VER,
		`SOC_REG_FLASH_SEL, `SOC_REG_GENIO_IN, `SOC_REG_GENIO_OUT,
		`SOC_REG_GENIO_OE, `SOC_REG_GENIO_W2S, `SOC_REG_GENIO_W2C};

	soc UUT (
		.clk48m_i        (clk48m),
		.rst_i           (rst),
		.bus_valid_i     (bus_valid),
		.bus_addr_i      (bus_addr),
		.bus_wdata_i     (bus_wdata),
		.bus_wstrb_i     (bus_wstrb),
		.bus_rdata_o     (bus_rdata),
		.bus_ready_o     (bus_ready),
		.bus_error_irq_o (bus_error_irq),
		.btn_i           (btn),
		.led_o           (led),
		.genio_in_i      (genio_in),
		.genio_out_o     (genio_out),
		.genio_oe_o      (genio_oe),
		.trace_en_o      (trace_en),
		.fsel_d_o        (fsel_d),
		.fsel_c_o        (fsel_c),
		.programn_o      (programn)
	);

	initial clk48m = 1'b0;
	always #20 clk48m = ~clk48m;

	// ------------------------------------------------------------
	// random numbers and model helpers
	// ------------------------------------------------------------
	// 16 bit Galois LFSR with taps at 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < count; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_step(lfsr_q);
		end
		return r;
	endfunction

	function automatic data_t misc_read_value(input reg_idx_t idx);
		logic [`SOC_BTN_W-1:0] btn_inv;
		btn_inv = ~btn;
		case (idx)
			`SOC_REG_LED:       return data_t'(led_m);
			`SOC_REG_BTN:       return data_t'(btn_inv);
			`SOC_REG_SOC_VER:   return `SOC_VERSION;
			`SOC_REG_FLASH_SEL: return data_t'(fsel_d_m);
			`SOC_REG_GENIO_IN:  return data_t'(genio_in);
			`SOC_REG_GENIO_OUT: return data_t'(genio_out_m);
			`SOC_REG_GENIO_OE:  return data_t'(genio_oe_m);
			default:            return '0;
		endcase
	endfunction

	function automatic void misc_write_model(input reg_idx_t idx, input data_t wdata);
		case (idx)
			`SOC_REG_LED:       led_m = wdata[`SOC_LED_W-1:0];
			`SOC_REG_SOC_VER:   trace_m = wdata[0];
			`SOC_REG_FLASH_SEL: fsel_d_m = wdata[0];
			`SOC_REG_GENIO_OUT: genio_out_m = wdata[`SOC_GENIO_W-1:0];
			`SOC_REG_GENIO_OE:  genio_oe_m = wdata[`SOC_GENIO_W-1:0];
			`SOC_REG_GENIO_W2S: genio_out_m = genio_out_m | wdata[`SOC_GENIO_W-1:0];
			`SOC_REG_GENIO_W2C: genio_out_m = genio_out_m & ~wdata[`SOC_GENIO_W-1:0];
			default: ;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("Test FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic check_outputs();
		check_value("led_o", 32'(led), 32'(led_m));
		check_value("trace_en_o", 32'(trace_en), 32'(trace_m));
		check_value("genio_out_o", 32'(genio_out), 32'(genio_out_m));
		check_value("genio_oe_o", 32'(genio_oe), 32'(genio_oe_m));
		check_value("fsel_d_o", 32'(fsel_d), 32'(fsel_d_m));
		check_value("programn_o", 32'(programn), 32'(!reload_m));
	endtask

	// ------------------------------------------------------------
	// one host access that starts and ends 2 ns after a rising edge
	// ------------------------------------------------------------
	task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t strb,
		input int exp_latency, input logic exp_irq, output data_t rdata);
		int waited;
		btn = `SOC_BTN_W'(rand_bits(`SOC_BTN_W));
		genio_in = `SOC_GENIO_W'(rand_bits(`SOC_GENIO_W));
		bus_valid = 1'b1;
		bus_addr = addr;
		bus_wdata = wdata;
		bus_wstrb = strb;
		waited = 0;
		@(negedge clk48m);
		while (!bus_ready) begin
			waited++;
			if (waited > 20) begin
				$display("bus ready did not rise within 20 cycles of valid");
				$display("Test FAILED");
				$fatal(1, "bus access timeout");
			end
			@(negedge clk48m);
		end
		rdata = bus_rdata;
		check_value("bus_ready_o latency", 32'(waited), 32'(exp_latency));
		check_value("bus_error_irq_o", 32'(bus_error_irq), 32'(exp_irq));
		@(posedge clk48m);
		#2;
		bus_valid = 1'b0;
		bus_wstrb = '0;
	endtask

	task automatic misc_phase(input int count);
		reg_idx_t idx;
		data_t    wdata;
		data_t    rdata;
		strb_t    strb;
		for (int n = 0; n < count; n++) begin
			if (rand_bits(1) != '0) begin
				idx = mapped_idx[int'(rand_bits(4)) % 9];
			end else begin
				idx = 5'(rand_bits(5));
			end
			wdata = rand_bits(32);
			// about half of the accesses are reads
			if (rand_bits(1) != '0) begin
				strb = '0;
			end else begin
				strb = 4'(rand_bits(4));
			end
			// keep the magic word out of random flash-select writes
			if (idx == `SOC_REG_FLASH_SEL && wdata[31:8] == `SOC_RELOAD_MAGIC) begin
				wdata[31:8] = ~wdata[31:8];
			end
			bus_access({`SOC_REGION_MISC, 21'(rand_bits(21)), idx, 2'b00}, wdata, strb,
				0, 1'b0, rdata);
			if (strb != '0) begin
				misc_write_model(idx, wdata);
			end else begin
				check_value("bus_rdata_o misc", rdata, misc_read_value(idx));
			end
			check_outputs();
		end
	endtask

	task automatic ram_access(input logic [7:0] word, input data_t wdata, input strb_t strb);
		data_t rdata;
		bus_access({`SOC_REGION_RAM, 18'(rand_bits(18)), word, 2'b00}, wdata, strb,
			1, 1'b0, rdata);
		if (strb == '0) begin
			check_value("bus_rdata_o ram", rdata, ram_m[word]);
		end
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				ram_m[word][8*b +: 8] = wdata[8*b +: 8];
			end
		end
	endtask

	task automatic error_phase(input int count);
		logic [3:0] region;
		data_t      rdata;
		for (int n = 0; n < count; n++) begin
			region = 4'(rand_bits(4));
			if (region == `SOC_REGION_MISC || region == `SOC_REGION_RAM) begin
				region = region + 4'd1;
			end
			bus_access({region, 28'(rand_bits(28))}, rand_bits(32), 4'(rand_bits(4)),
				0, 1'b1, rdata);
			check_value("bus_rdata_o error", rdata, `SOC_BUS_ERR_DATA);
			check_outputs();
		end
	endtask

	// flash-select write at edge N followed by the pulse and reload timing
	task automatic flash_select_sequence(input logic magic);
		data_t wdata;
		data_t rdata;
		wdata = rand_bits(32);
		if (magic) begin
			wdata[31:8] = `SOC_RELOAD_MAGIC;
		end else if (wdata[31:8] == `SOC_RELOAD_MAGIC) begin
			wdata[31:8] = ~wdata[31:8];
		end
		bus_access({`SOC_REGION_MISC, 21'd0, `SOC_REG_FLASH_SEL, 2'b00}, wdata, 4'hF,
			0, 1'b0, rdata);
		fsel_d_m = wdata[0];
		for (int k = 0; k < 10; k++) begin
			@(negedge clk48m);
			if (magic && k == 7) begin
				reload_m = 1'b1;
			end
			check_value("fsel_c_o", 32'(fsel_c), 32'(k >= 2 && k <= 4));
			check_outputs();
		end
		@(posedge clk48m);
		#2;
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		lfsr_q = 16'd64577;
		rst = 1'b1;
		bus_valid = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		bus_wstrb = '0;
		btn = '0;
		genio_in = '0;
		led_m = '0;
		trace_m = 1'b0;
		genio_out_m = '0;
		genio_oe_m = '0;
		fsel_d_m = 1'b0;
		reload_m = 1'b0;
		repeat (4) @(posedge clk48m);
		#2;
		rst = 1'b0;

		@(negedge clk48m);
		check_value("bus_ready_o", 32'(bus_ready), 32'd0);
		check_value("bus_error_irq_o", 32'(bus_error_irq), 32'd0);
		check_value("fsel_c_o", 32'(fsel_c), 32'd0);
		check_outputs();
		@(posedge clk48m);
		#2;

		misc_phase(300);
		// every RAM word gets a defined value before random traffic
		for (int w = 0; w < `SOC_RAM_WORDS; w++) begin
			ram_access(8'(w), rand_bits(32), 4'hF);
		end
		for (int n = 0; n < 300; n++) begin
			ram_access(8'(rand_bits(8)), rand_bits(32), 4'(rand_bits(4)));
		end
		error_phase(40);

		flash_select_sequence(1'b0);
		flash_select_sequence(1'b1);
		// reload must stay requested through later traffic
		misc_phase(60);
		error_phase(10);

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
verilog/soc_pkg.sv
verilog/soc_bus_if.sv
verilog/bus_decoder.sv
verilog/misc_regs.sv
verilog/fsel_sequencer.sv
verilog/scratch_ram.sv
verilog/soc.sv
bench/tb_soc.sv

/* Makefile */
# Verilator build and run of the SoC bus testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_soc -f tb.f -Mdir obj_dir -o Vtb_soc

run: compile
	./obj_dir/Vtb_soc

clean:
	rm -rf obj_dir
